//--- mrd_params.svh
`ifndef MRD_PARAMS_SVH
`define MRD_PARAMS_SVH

// ------------------------------------------------------------
// memory layout
// ------------------------------------------------------------

// banks, fixed by the mod-7 address mapping
`define MRD_NUM_BANKS 7
// one real or imaginary part
`define MRD_DATA_W 18
// linear sample address
`define MRD_ADDR_W 12
// word address inside one bank, 512 deep
`define MRD_BANK_AW 9

// ------------------------------------------------------------
// operand path
// ------------------------------------------------------------

// lanes per beat, enough for radix 5
`define MRD_LANES 5
// group issue to operand beat
`define MRD_RD_LAT 4

`endif

//--- mrd_pkg.sv
`include "mrd_params.svh"

package mrd_pkg;

	// ------------------------------------------------------------
	// stage sequencing
	// ------------------------------------------------------------

	typedef enum logic [1:0]
	{
		st_idle       = 2'd0,
		st_rd         = 2'd1,
		st_wait_drain = 2'd2,
		st_done       = 2'd3
	} mrd_state_e;

	// register select, wb_adr[2:0] with wb_adr[13] set
	typedef enum logic [2:0]
	{
		reg_points = 3'd0,
		reg_radix  = 3'd1,
		reg_span   = 3'd2,
		reg_start  = 3'd3,
		reg_status = 3'd4
	} mrd_reg_e;

	// one stage as programmed by the host
	typedef struct packed
	{
		logic [`MRD_ADDR_W-1:0] points;
		logic [2:0]             radix;
		logic [`MRD_ADDR_W-1:0] span;
	} mrd_stage_cfg_t;

	// ------------------------------------------------------------
	// bank reads and operand beat
	// ------------------------------------------------------------

	typedef struct packed
	{
		logic [`MRD_NUM_BANKS-1:0]                  en;
		logic [`MRD_NUM_BANKS-1:0][`MRD_BANK_AW-1:0] word;
	} mrd_rd_req_t;

	// bank index 7 marks an unused lane
	typedef struct packed
	{
		logic                                  valid;
		logic [2:0]                            radix;
		logic [`MRD_LANES-1:0][2:0]            bank;
		logic [`MRD_LANES-1:0][`MRD_DATA_W-1:0] re;
		logic [`MRD_LANES-1:0][`MRD_DATA_W-1:0] im;
	} mrd_operand_t;

endpackage

//--- mrd_bank_map.sv
`include "mrd_params.svh"

module mrd_bank_map
(
	input  logic [`MRD_ADDR_W-1:0]  addr,
	output logic [`MRD_BANK_AW-1:0] bank_word,
	output logic [2:0]              bank
);

	// 585 = (4096 - 1) / 7, so addr * 585 >> 12 is floor(addr / 7) or one short
	logic [21:0] recip;
	logic [9:0]  q_est;
	logic [3:0]  q7_lo;
	logic [3:0]  r_est;
	logic        fix;
	logic [9:0]  q_fix;

	assign recip = addr * 10'd585;
	assign q_est = recip[21:12];

	// remainder only needs the low nibble, true value is 0..13
	assign q7_lo = q_est[3:0] * 4'd7;
	assign r_est = addr[3:0] - q7_lo;

	// correction step
	assign fix   = (r_est >= 4'd7);
	assign q_fix = fix ? q_est + 10'd1 : q_est;

	// words past 511 wrap, only 3584 samples fit in the banks
	assign bank_word = q_fix[`MRD_BANK_AW-1:0];
	assign bank      = fix ? 3'(r_est - 4'd7) : r_est[2:0];

endmodule

//--- mrd_addr_gen.sv
`include "mrd_params.svh"

module mrd_addr_gen
(
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   go,
	input  mrd_pkg::mrd_stage_cfg_t                cfg,
	output logic                                   issue,
	output logic                                   last,
	output logic [`MRD_LANES-1:0][`MRD_ADDR_W-1:0] addrs,
	output logic [`MRD_LANES-1:0]                  lane_en
);

	logic                   active;
	// g mod span
	logic [`MRD_ADDR_W-1:0] inner;
	// (g div span) * span * radix
	logic [`MRD_ADDR_W-1:0] outer;
	// points covered so far, g * radix
	logic [`MRD_ADDR_W-1:0] consumed;
	logic [`MRD_ADDR_W:0]   next_cnt;
	logic [`MRD_ADDR_W-1:0] stride;
	logic [`MRD_ADDR_W-1:0] base;
	logic                   final_grp;

	assign stride    = `MRD_ADDR_W'(cfg.span * cfg.radix);
	assign base      = outer + inner;
	assign next_cnt  = {1'b0, consumed} + cfg.radix;
	// points / radix groups, counted without a divider
	assign final_grp = (next_cnt >= {1'b0, cfg.points});

	// ------------------------------------------------------------
	// group counters
	// ------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			active   <= 1'b0;
			inner    <= '0;
			outer    <= '0;
			consumed <= '0;
		end
		else if (go)
		begin
			active   <= 1'b1;
			inner    <= '0;
			outer    <= '0;
			consumed <= '0;
		end
		else if (active)
		begin
			consumed <= next_cnt[`MRD_ADDR_W-1:0];
			if (final_grp)
				active <= 1'b0;
			// inner wraps at span, outer jumps a whole block
			if (inner == cfg.span - `MRD_ADDR_W'(1))
			begin
				inner <= '0;
				outer <= outer + stride;
			end
			else
				inner <= inner + `MRD_ADDR_W'(1);
		end
	end

	// ------------------------------------------------------------
	// registered group outputs
	// ------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			issue   <= 1'b0;
			last    <= 1'b0;
			lane_en <= '0;
		end
		else
		begin
			issue <= active;
			last  <= active & final_grp;
			for (int j = 0; j < `MRD_LANES; j++)
				lane_en[j] <= (j < cfg.radix);
		end
	end

	// operand j at base + j * span
	always_ff @(posedge clk)
	begin
		for (int j = 0; j < `MRD_LANES; j++)
			addrs[j] <= base + `MRD_ADDR_W'(j) * cfg.span;
	end

endmodule

//--- mrd_bank_mem.sv
`include "mrd_params.svh"

module mrd_bank_mem
(
	input  logic                                          clk,
	input  logic                                          we,
	input  logic [2:0]                                    wr_bank,
	input  logic [`MRD_BANK_AW-1:0]                       wr_word,
	input  logic [2*`MRD_DATA_W-1:0]                      wr_data,
	input  mrd_pkg::mrd_rd_req_t                          rd_req,
	output logic [`MRD_NUM_BANKS-1:0][2*`MRD_DATA_W-1:0] rd_data
);

	// ------------------------------------------------------------
	// one simple dual-port array per bank
	// ------------------------------------------------------------
	genvar b;
	generate
		for (b = 0; b < `MRD_NUM_BANKS; b++)
		begin : g_bank
			// real part in the upper half
			logic [2*`MRD_DATA_W-1:0] mem [0:(1 << `MRD_BANK_AW)-1];

			// host write port
			always_ff @(posedge clk)
			begin
				if (we && wr_bank == 3'(b))
					mem[wr_word] <= wr_data;
			end

			// read port, output holds while not enabled
			always_ff @(posedge clk)
			begin
				if (rd_req.en[b])
					rd_data[b] <= mem[rd_req.word[b]];
			end
		end
	endgenerate

endmodule

//--- mrd_rd_seq.sv
`include "mrd_params.svh"

module mrd_rd_seq
(
	input  logic                                          clk,
	input  logic                                          rst_n,
	input  logic                                          go,
	input  mrd_pkg::mrd_stage_cfg_t                       cfg,
	output mrd_pkg::mrd_rd_req_t                          rd_req,
	input  logic [`MRD_NUM_BANKS-1:0][2*`MRD_DATA_W-1:0] rd_data,
	output mrd_pkg::mrd_operand_t                         operand,
	output logic                                          rd_end,
	output mrd_pkg::mrd_state_e                           state
);
	import mrd_pkg::*;

	// group from the address generator
	logic                                    issue;
	logic                                    last;
	logic [`MRD_LANES-1:0][`MRD_ADDR_W-1:0]  addrs;
	logic [`MRD_LANES-1:0]                   lane_en;
	logic [`MRD_LANES-1:0][`MRD_BANK_AW-1:0] map_word;
	logic [`MRD_LANES-1:0][2:0]              map_bank;

	// lane map, one set per pipeline stage
	logic [`MRD_LANES-1:0][`MRD_BANK_AW-1:0] lane_word_a;
	logic [`MRD_LANES-1:0][2:0]              lane_bank_a;
	logic [`MRD_LANES-1:0][2:0]              lane_bank_b;
	logic [`MRD_LANES-1:0][2:0]              lane_bank_c;
	logic                                    v_a, v_b, v_c;
	logic                                    l_a, l_b, l_c;
	logic                                    last_d;
	logic                                    conflict_a;

	// per-bank request
	logic [`MRD_NUM_BANKS-1:0]                   req_hit;
	logic [`MRD_NUM_BANKS-1:0][`MRD_BANK_AW-1:0] req_word_nxt;
	logic [`MRD_NUM_BANKS-1:0]                   req_en;
	logic [`MRD_NUM_BANKS-1:0][`MRD_BANK_AW-1:0] req_word;

	// output beat
	logic                                   op_valid;
	logic [2:0]                             op_radix;
	logic [`MRD_LANES-1:0][2:0]             op_bank;
	logic [`MRD_LANES-1:0][`MRD_DATA_W-1:0] op_re;
	logic [`MRD_LANES-1:0][`MRD_DATA_W-1:0] op_im;

	// ------------------------------------------------------------
	// cycle 1, group addresses
	// ------------------------------------------------------------
	mrd_addr_gen u_addr_gen
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.go      (go),
		.cfg     (cfg),
		.issue   (issue),
		.last    (last),
		.addrs   (addrs),
		.lane_en (lane_en)
	);

	genvar k;
	generate
		for (k = 0; k < `MRD_LANES; k++)
		begin : g_map
			mrd_bank_map u_bank_map
			(
				.addr      (addrs[k]),
				.bank_word (map_word[k]),
				.bank      (map_bank[k])
			);
		end
	endgenerate

	// ------------------------------------------------------------
	// cycle 2, registered bank map
	// ------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		for (int j = 0; j < `MRD_LANES; j++)
		begin
			// lanes at or above the radix go to index 7
			lane_bank_a[j] <= lane_en[j] ? map_bank[j] : 3'd7;
			lane_word_a[j] <= map_word[j];
		end
		// indexes follow the read so data can be steered back
		lane_bank_b <= lane_bank_a;
		lane_bank_c <= lane_bank_b;
	end

	// bank to lane lookup, lowest lane wins
	always_comb
	begin
		req_hit      = '0;
		req_word_nxt = '0;
		for (int b = 0; b < `MRD_NUM_BANKS; b++)
		begin
			for (int j = `MRD_LANES - 1; j >= 0; j--)
			begin
				if (lane_bank_a[j] == 3'(b))
				begin
					req_hit[b]      = 1'b1;
					req_word_nxt[b] = lane_word_a[j];
				end
			end
		end
	end

	// two enabled lanes on one bank
	always_comb
	begin
		conflict_a = 1'b0;
		for (int j = 0; j < `MRD_LANES; j++)
			for (int i = j + 1; i < `MRD_LANES; i++)
				if (lane_bank_a[j] != 3'd7 && lane_bank_a[j] == lane_bank_a[i])
					conflict_a = 1'b1;
	end

	// ------------------------------------------------------------
	// cycle 3, bank read request
	// ------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			req_en <= '0;
		else
			req_en <= v_a ? req_hit : '0;
	end

	always_ff @(posedge clk)
	begin
		req_word <= req_word_nxt;
	end

	assign rd_req = '{en: req_en, word: req_word};

	// issue and last ride along the pipe
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			v_a    <= 1'b0;
			v_b    <= 1'b0;
			v_c    <= 1'b0;
			l_a    <= 1'b0;
			l_b    <= 1'b0;
			l_c    <= 1'b0;
			op_valid <= 1'b0;
			last_d <= 1'b0;
			rd_end <= 1'b0;
		end
		else
		begin
			v_a    <= issue;
			v_b    <= v_a;
			v_c    <= v_b;
			l_a    <= issue & last;
			l_b    <= l_a;
			l_c    <= l_b;
			op_valid <= v_c;
			last_d <= v_c & l_c;
			// one cycle after the final beat
			rd_end <= last_d;
		end
	end

	// ------------------------------------------------------------
	// cycle 4, realign bank outputs into lanes
	// ------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		op_radix <= cfg.radix;
		for (int j = 0; j < `MRD_LANES; j++)
		begin
			op_bank[j] <= lane_bank_c[j];
			if (lane_bank_c[j] == 3'd7)
			begin
				op_re[j] <= '0;
				op_im[j] <= '0;
			end
			else
				{op_re[j], op_im[j]} <= rd_data[lane_bank_c[j]];
		end
	end

	assign operand = '{valid: op_valid, radix: op_radix, bank: op_bank,
		re: op_re, im: op_im};

	// ------------------------------------------------------------
	// stage state
	// ------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state <= st_idle;
		else
		begin
			case (state)
				st_idle:
					if (go)
						state <= st_rd;
				st_rd:
					if (issue && last)
						state <= st_wait_drain;
				// done together with rd_end
				st_wait_drain:
					if (last_d)
						state <= st_done;
				default:
					state <= go ? st_rd : st_idle;
			endcase
		end
	end

	// a span that is a multiple of 7 puts two lanes on one bank
	a_no_conflict : assert property (@(posedge clk) disable iff (!rst_n)
		v_a |-> !conflict_a);

	a_valid_in_stage : assert property (@(posedge clk) disable iff (!rst_n)
		op_valid |-> (state == st_rd || state == st_wait_drain));

endmodule

//--- mrd_wb_ctrl.sv
`include "mrd_params.svh"

module mrd_wb_ctrl
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_we,
	input  logic [13:0]              wb_adr,
	input  logic [31:0]              wb_dat_w,
	output logic [31:0]              wb_dat_r,
	output logic                     wb_ack,
	input  mrd_pkg::mrd_state_e      state,
	output mrd_pkg::mrd_stage_cfg_t  cfg,
	output logic                     go,
	output logic                     we,
	output logic [2:0]               wr_bank,
	output logic [`MRD_BANK_AW-1:0]  wr_word,
	output logic [2*`MRD_DATA_W-1:0] wr_data
);
	import mrd_pkg::*;

	logic                    acc;
	logic                    smp_wr;
	logic                    reg_wr;
	mrd_reg_e                reg_sel;
	logic                    busy;
	logic                    done_flag;
	logic                    start_req;
	logic [`MRD_DATA_W-1:0]  re_hold;
	logic [`MRD_BANK_AW-1:0] map_word;
	logic [2:0]              map_bank;

	// new transfer, ack of the previous one already gone
	assign acc       = wb_cyc & wb_stb & ~wb_ack;
	assign smp_wr    = acc & wb_we & ~wb_adr[13];
	assign reg_wr    = acc & wb_we & wb_adr[13];
	assign reg_sel   = mrd_reg_e'(wb_adr[2:0]);
	assign busy      = (state == st_rd) || (state == st_wait_drain) || go;
	assign start_req = reg_wr && reg_sel == reg_start && wb_dat_w[0] && !busy;

	mrd_bank_map u_bank_map
	(
		.addr      (wb_adr[`MRD_ADDR_W-1:0]),
		.bank_word (map_word),
		.bank      (map_bank)
	);

	// ------------------------------------------------------------
	// bus handshake and status read
	// ------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			wb_ack <= 1'b0;
		else
			wb_ack <= acc;
	end

	always_ff @(posedge clk)
	begin
		if (acc && !wb_we && wb_adr[13] && reg_sel == reg_status)
			wb_dat_r <= {30'd0, done_flag, busy};
		else
			wb_dat_r <= '0;
	end

	// ------------------------------------------------------------
	// stage registers, start and done
	// ------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cfg       <= '{points: '0, radix: 3'd2, span: `MRD_ADDR_W'(1)};
			go        <= 1'b0;
			done_flag <= 1'b0;
		end
		else
		begin
			go <= start_req;
			if (reg_wr && reg_sel == reg_points)
				cfg.points <= wb_dat_w[`MRD_ADDR_W-1:0];
			if (reg_wr && reg_sel == reg_radix)
				cfg.radix <= wb_dat_w[2:0];
			if (reg_wr && reg_sel == reg_span)
				cfg.span <= wb_dat_w[`MRD_ADDR_W-1:0];
			// sticky until the next start
			if (start_req)
				done_flag <= 1'b0;
			else if (state == st_done)
				done_flag <= 1'b1;
		end
	end

	// ------------------------------------------------------------
	// sample writes, real half then imaginary half
	// ------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			we <= 1'b0;
		else
			we <= smp_wr & wb_adr[12];
	end

	always_ff @(posedge clk)
	begin
		if (smp_wr && !wb_adr[12])
			re_hold <= wb_dat_w[`MRD_DATA_W-1:0];
		// second half commits
		if (smp_wr && wb_adr[12])
		begin
			wr_bank <= map_bank;
			wr_word <= map_word;
			wr_data <= {re_hold, wb_dat_w[`MRD_DATA_W-1:0]};
		end
	end

	a_no_load_busy : assert property (@(posedge clk) disable iff (!rst_n)
		smp_wr |-> !busy);

	a_radix_range : assert property (@(posedge clk) disable iff (!rst_n)
		(reg_wr && reg_sel == reg_radix) |-> wb_dat_w inside {[2:5]});

endmodule

//--- mrd_rd_top.sv
`include "mrd_params.svh"

module mrd_rd_top
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  logic [13:0]           wb_adr,
	input  logic [31:0]           wb_dat_w,
	output logic [31:0]           wb_dat_r,
	output logic                  wb_ack,
	output mrd_pkg::mrd_operand_t operand,
	output logic                  rd_end
);
	import mrd_pkg::*;

	// ------------------------------------------------------------
	// control to sequencer
	// ------------------------------------------------------------
	mrd_stage_cfg_t cfg;
	logic           go;
	mrd_state_e     state;

	// host write port into the banks
	logic                     we;
	logic [2:0]               wr_bank;
	logic [`MRD_BANK_AW-1:0]  wr_word;
	logic [2*`MRD_DATA_W-1:0] wr_data;

	// sequencer read port
	mrd_rd_req_t                                   rd_req;
	logic [`MRD_NUM_BANKS-1:0][2*`MRD_DATA_W-1:0] rd_data;

	mrd_wb_ctrl u_wb_ctrl
	(
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.state    (state),
		.cfg      (cfg),
		.go       (go),
		.we       (we),
		.wr_bank  (wr_bank),
		.wr_word  (wr_word),
		.wr_data  (wr_data)
	);

	mrd_rd_seq u_rd_seq
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.go      (go),
		.cfg     (cfg),
		.rd_req  (rd_req),
		.rd_data (rd_data),
		.operand (operand),
		.rd_end  (rd_end),
		.state   (state)
	);

	mrd_bank_mem u_bank_mem
	(
		.clk     (clk),
		.we      (we),
		.wr_bank (wr_bank),
		.wr_word (wr_word),
		.wr_data (wr_data),
		.rd_req  (rd_req),
		.rd_data (rd_data)
	);

endmodule

//--- mrd_clk_gen.sv
module mrd_clk_gen
(
	output logic clk
);
	timeunit 1ns;
	timeprecision 100ps;

	// 8 ns period
	localparam realtime half_period = 4ns;

	initial
	begin
		clk = 1'b0;
		forever
			#(half_period) clk = ~clk;
	end

endmodule

//--- mrd_tb.sv
`include "mrd_params.svh"

module mrd_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import mrd_pkg::*;

	// load plus three short stages stays far below this
	localparam int timeout_cycles = 3000;
	// go, then one cycle into the group counter, one to issue, then the read pipe
	localparam int first_beat = `MRD_RD_LAT + 2;
	localparam int n_samples = 60;

	logic         clk;
	logic         rst_n;
	logic         wb_cyc;
	logic         wb_stb;
	logic         wb_we;
	logic [13:0]  wb_adr;
	logic [31:0]  wb_dat_w;
	logic [31:0]  wb_dat_r;
	logic         wb_ack;
	mrd_operand_t operand;
	logic         rd_end;

	// host copy of the sample banks
	logic [`MRD_DATA_W-1:0] model_re [0:63];
	logic [`MRD_DATA_W-1:0] model_im [0:63];

	integer seed;
	int     cyc_cnt = 0;
	int     go_cyc;
	int     beat_cnt;
	logic   stage_on;
	int     cur_radix;
	int     cur_span;
	int     groups;
	int     err_cnt;
	int     tests_run;
	int     tests_failed;
	string  test_name;

	mrd_clk_gen u_clk_gen
	(
		.clk (clk)
	);

	mrd_rd_top mrd_rd_top_i
	(
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.operand  (operand),
		.rd_end   (rd_end)
	);

	// ------------------------------------------------------------
	// reference model of one stage
	// ------------------------------------------------------------

	// group g, operand j
	function automatic int lane_addr(int g, int j);
		int base;
		base = (g / cur_span) * cur_span * cur_radix + (g % cur_span);
		return base + j * cur_span;
	endfunction

	function automatic logic [35:0] lane_word(int g, int j);
		int a;
		a = lane_addr(g, j);
		// unused lanes carry zero
		if (j >= cur_radix)
			return '0;
		return {model_re[a % 64], model_im[a % 64]};
	endfunction

	function automatic logic [2:0] lane_bank(int g, int j);
		if (j >= cur_radix)
			return 3'd7;
		return 3'(lane_addr(g, j) % 7);
	endfunction

	// beat k due first_beat + k cycles after go
	function automatic logic beat_due();
		return stage_on && cyc_cnt >= go_cyc + first_beat
			&& cyc_cnt < go_cyc + first_beat + groups;
	endfunction

	// ------------------------------------------------------------
	// cycle count, beat count and watchdog
	// ------------------------------------------------------------
	always @(posedge clk)
	begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_cnt >= timeout_cycles)
		begin
			$display("timeout: run stopped after %0d cycles in test %s", cyc_cnt, test_name);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// group index of the beat on the bus
	always @(posedge clk)
	begin
		if (!rst_n || rd_end)
			beat_cnt <= 0;
		else if (operand.valid)
			beat_cnt <= beat_cnt + 1;
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------

	// handshake, sampled on the rising edge
	a_ack_next : assert property (@(posedge clk) disable iff (!rst_n)
		(wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
	else
	begin
		$display("FAILED %s bus ack: expected 1, actual 0", test_name);
		err_cnt++;
	end

	a_ack_single : assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
	else
	begin
		$display("FAILED %s bus ack width: expected 0, actual 1", test_name);
		err_cnt++;
	end

	// beats sampled mid-cycle
	a_beat_timing : assert property (@(negedge clk) disable iff (!rst_n)
		operand.valid == beat_due())
	else
	begin
		$display("FAILED %s beat timing: expected valid %0b, actual %0b",
			test_name, beat_due(), operand.valid);
		err_cnt++;
	end

	a_beat_radix : assert property (@(negedge clk) disable iff (!rst_n)
		operand.valid |-> operand.radix == 3'(cur_radix))
	else
	begin
		$display("FAILED %s radix: expected %0d, actual %0d",
			test_name, cur_radix, operand.radix);
		err_cnt++;
	end

	genvar j;
	generate
		for (j = 0; j < `MRD_LANES; j++)
		begin : g_lane
			a_lane_word : assert property (@(negedge clk) disable iff (!rst_n)
				operand.valid |-> {operand.re[j], operand.im[j]} == lane_word(beat_cnt, j))
			else
			begin
				$display("FAILED %s lane %0d group %0d: expected %h, actual %h", test_name,
					j, beat_cnt, lane_word(beat_cnt, j), {operand.re[j], operand.im[j]});
				err_cnt++;
			end

			a_lane_bank : assert property (@(negedge clk) disable iff (!rst_n)
				operand.valid |-> operand.bank[j] == lane_bank(beat_cnt, j))
			else
			begin
				$display("FAILED %s lane %0d bank: expected %0d, actual %0d", test_name,
					j, lane_bank(beat_cnt, j), operand.bank[j]);
				err_cnt++;
			end
		end
	endgenerate

	// end pulse right after the last beat
	a_end_time : assert property (@(negedge clk) disable iff (!rst_n)
		rd_end |-> (stage_on && cyc_cnt == go_cyc + first_beat + groups))
	else
	begin
		$display("FAILED %s rd_end cycle: expected %0d, actual %0d",
			test_name, go_cyc + first_beat + groups, cyc_cnt);
		err_cnt++;
	end

	a_end_count : assert property (@(negedge clk) disable iff (!rst_n)
		rd_end |-> beat_cnt == groups)
	else
	begin
		$display("FAILED %s beat count: expected %0d, actual %0d", test_name, groups, beat_cnt);
		err_cnt++;
	end

	a_end_once : assert property (@(negedge clk) disable iff (!rst_n)
		rd_end |=> !rd_end)
	else
	begin
		$display("FAILED %s rd_end width: expected 0, actual 1", test_name);
		err_cnt++;
	end

	// ------------------------------------------------------------
	// bus tasks
	// ------------------------------------------------------------
	task automatic bus_access(input logic we, input logic [13:0] adr, input logic [31:0] wdata,
		output logic [31:0] rdata, output int ack_cyc);
		@(negedge clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdata;
		@(negedge clk);
		while (!wb_ack)
			@(negedge clk);
		rdata   = wb_dat_r;
		ack_cyc = cyc_cnt;
		// strobe drops once ack is seen
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic reg_write(input mrd_reg_e sel, input int value, output int ack_cyc);
		logic [31:0] rdata;
		bus_access(1'b1, {1'b1, 10'd0, sel}, 32'(value), rdata, ack_cyc);
	endtask

	// real half first, imaginary half commits
	task automatic sample_write(input int addr, input logic [17:0] re, input logic [17:0] im);
		logic [31:0] rdata;
		int          ack_cyc;
		bus_access(1'b1, {2'b00, 12'(addr)}, {14'd0, re}, rdata, ack_cyc);
		bus_access(1'b1, {2'b01, 12'(addr)}, {14'd0, im}, rdata, ack_cyc);
	endtask

	task automatic end_test(input int err_before);
		tests_run++;
		if (err_cnt != err_before)
			tests_failed++;
		$display("test %s: %s", test_name, (err_cnt == err_before) ? "ok" : "errors");
	endtask

	// ------------------------------------------------------------
	// one stage, programmed and run to its end pulse
	// ------------------------------------------------------------
	task automatic run_stage(input string name, input int points, input int radix,
		input int span);
		int          err_before;
		int          ack_cyc;
		logic [31:0] status;
		test_name  = name;
		err_before = err_cnt;
		cur_radix  = radix;
		cur_span   = span;
		groups     = points / radix;
		reg_write(reg_points, points, ack_cyc);
		reg_write(reg_radix, radix, ack_cyc);
		reg_write(reg_span, span, ack_cyc);
		reg_write(reg_start, 1, ack_cyc);
		// go is high in the start ack cycle
		go_cyc   = ack_cyc;
		stage_on = 1'b1;
		while (!rd_end)
			@(negedge clk);
		repeat (2)
			@(negedge clk);
		bus_access(1'b0, {1'b1, 10'd0, reg_status}, 32'd0, status, ack_cyc);
		// done set, busy clear
		assert (status[1:0] == 2'b10)
		else
		begin
			$display("FAILED %s status: expected 2, actual %0d", test_name, status[1:0]);
			err_cnt++;
		end
		end_test(err_before);
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial
	begin
		int          err_before;
		logic [31:0] rnd_re;
		logic [31:0] rnd_im;
		rst_n        = 1'b0;
		wb_cyc       = 1'b0;
		wb_stb       = 1'b0;
		wb_we        = 1'b0;
		wb_adr       = '0;
		wb_dat_w     = '0;
		seed         = 15188;
		stage_on     = 1'b0;
		go_cyc       = 0;
		cur_radix    = 2;
		cur_span     = 1;
		groups       = 0;
		err_cnt      = 0;
		tests_run    = 0;
		tests_failed = 0;

		// five rising edges in reset
		test_name  = "reset";
		err_before = err_cnt;
		repeat (5)
			@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		assert (!operand.valid && !rd_end && !wb_ack)
		else
		begin
			$display("FAILED reset valid/rd_end/ack: expected 000, actual %b%b%b",
				operand.valid, rd_end, wb_ack);
			err_cnt++;
		end
		end_test(err_before);

		// random samples, mirrored in the model
		test_name  = "load";
		err_before = err_cnt;
		for (int a = 0; a < n_samples; a++)
		begin
			rnd_re      = $random(seed);
			rnd_im      = $random(seed);
			model_re[a] = rnd_re[`MRD_DATA_W-1:0];
			model_im[a] = rnd_im[`MRD_DATA_W-1:0];
			sample_write(a, model_re[a], model_im[a]);
		end
		end_test(err_before);

		run_stage("radix3_span20", 60, 3, 20);
		run_stage("radix4_span5", 60, 4, 5);
		run_stage("radix5_span1", 60, 5, 1);

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0 && tests_failed == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+.
mrd_pkg.sv
mrd_bank_map.sv
mrd_addr_gen.sv
mrd_bank_mem.sv
mrd_rd_seq.sv
mrd_wb_ctrl.sv
mrd_rd_top.sv
mrd_clk_gen.sv
mrd_tb.sv
